// ==== rv_pkg.sv ====
//--------------------------------------------------------------------------
// Shared widths, types and encodings for the RV32I decode stage.
// Import inside module bodies; use rv_pkg:: names in port lists.
//--------------------------------------------------------------------------

package rv_pkg;

    // Fixed RV32I widths
    localparam int XLEN       = 32;             // Data and address width
    localparam int REG_ADDR_W = 5;              // Register index width
    localparam int NUM_REGS   = 2**REG_ADDR_W;  // x0..x31
    localparam int OPC_W      = 7;              // Major opcode field
    localparam int FUNCT3_W   = 3;
    localparam int ALU_OP_W   = 4;

    typedef logic [XLEN-1:0]       word_t;      // Data, immediate or control word
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // Register index
    typedef logic [XLEN-1:0]       instr_t;     // Raw instruction word

    // Sequential PC step, no compressed instructions
    localparam word_t PC_INC = 32'd4;

    // RV32I major opcodes, instr[6:0]
    localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
    localparam logic [OPC_W-1:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;
    localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPC_W-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011;
    localparam logic [OPC_W-1:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;

    // Control word bit positions
    localparam int CTL_REG_WRITE   = 0;   // Writeback to rd
    localparam int CTL_MEM_READ    = 1;   // Data memory load
    localparam int CTL_MEM_WRITE   = 2;   // Data memory store
    localparam int CTL_MEM_TO_REG  = 3;   // Writeback from memory
    localparam int CTL_ALU_SRC_IMM = 4;   // ALU B operand is imm
    localparam int CTL_ALU_SRC_PC  = 5;   // ALU A operand is PC
    localparam int CTL_BRANCH      = 6;
    localparam int CTL_JUMP        = 7;
    localparam int CTL_ALU_OP_LSB  = 8;   // 4-bit ALU op field
    localparam int CTL_ALU_OP_MSB  = 11;
    localparam int CTL_FUNCT3_LSB  = 12;  // funct3 copy, bits 12..14
    // Bits 15..31 stay zero

    // ALU operation codes, MSB mirrors funct7[5] where it matters
    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'b0000;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'b0001;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'b0010;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'b0011;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'b0100;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'b0101;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'b0110;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'b0111;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'b1000;
    localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'b1101;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'b1111;  // LUI, result = imm

endpackage

// ==== rv_ctrl_decoder.sv ====
//--------------------------------------------------------------------------
// Combinational RV32I control decoder. Maps one instruction word to the
// 32-bit control word and the sign-extended immediate for the ID/EX stage.
// Unknown opcodes give an all-zero control word and immediate (bubble).
//--------------------------------------------------------------------------

module rv_ctrl_decoder (
    input  rv_pkg::instr_t i_instr,  // Instruction from IF/ID
    output rv_pkg::word_t  o_ctrl,   // Control word
    output rv_pkg::word_t  o_imm     // Sign-extended immediate
);

    import rv_pkg::*;

    logic [OPC_W-1:0]    opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic                funct7_b30;  // SUB / SRA select
    logic [ALU_OP_W-1:0] alu_op;
    word_t               ctrl;
    word_t               imm;

    assign opcode     = i_instr[6:0];
    assign funct3     = i_instr[14:12];
    assign funct7_b30 = i_instr[30];

    // ALU op for OP and OP-IMM, from funct3 and funct7[5]
    function automatic logic [ALU_OP_W-1:0] arith_op(
        input logic [FUNCT3_W-1:0] f3,
        input logic                b30,
        input logic                is_reg  // R-type, b30 also picks SUB
    );
        logic [ALU_OP_W-1:0] op;
        case (f3)
            3'b000:  op = (is_reg && b30) ? ALU_SUB : ALU_ADD;  // No SUBI
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = b30 ? ALU_SRA : ALU_SRL;  // Same bit for SRAI
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // Control bits and ALU op per opcode class
    always_comb begin
        ctrl   = '0;           // Bubble unless a known opcode matches
        alu_op = ALU_ADD;
        case (opcode)
            OPC_LUI: begin
                ctrl[CTL_REG_WRITE]   = 1'b1;
                ctrl[CTL_ALU_SRC_IMM] = 1'b1;
                alu_op                = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                ctrl[CTL_REG_WRITE]   = 1'b1;
                ctrl[CTL_ALU_SRC_IMM] = 1'b1;
                ctrl[CTL_ALU_SRC_PC]  = 1'b1;  // PC + imm
            end
            OPC_JAL: begin
                ctrl[CTL_REG_WRITE]   = 1'b1;  // rd = PC+4
                ctrl[CTL_JUMP]        = 1'b1;
                ctrl[CTL_ALU_SRC_IMM] = 1'b1;
                ctrl[CTL_ALU_SRC_PC]  = 1'b1;  // Target PC + imm
            end
            OPC_JALR: begin
                ctrl[CTL_REG_WRITE]   = 1'b1;
                ctrl[CTL_JUMP]        = 1'b1;
                ctrl[CTL_ALU_SRC_IMM] = 1'b1;  // Target rs1 + imm
            end
            OPC_BRANCH: begin
                ctrl[CTL_BRANCH]      = 1'b1;
                alu_op                = ALU_SUB;  // Compare rs1 - rs2
            end
            OPC_LOAD: begin
                ctrl[CTL_REG_WRITE]   = 1'b1;
                ctrl[CTL_MEM_READ]    = 1'b1;
                ctrl[CTL_MEM_TO_REG]  = 1'b1;
                ctrl[CTL_ALU_SRC_IMM] = 1'b1;  // Address rs1 + imm
            end
            OPC_STORE: begin
                ctrl[CTL_MEM_WRITE]   = 1'b1;
                ctrl[CTL_ALU_SRC_IMM] = 1'b1;
            end
            OPC_OPIMM: begin
                ctrl[CTL_REG_WRITE]   = 1'b1;
                ctrl[CTL_ALU_SRC_IMM] = 1'b1;
                alu_op                = arith_op(funct3, funct7_b30, 1'b0);
            end
            OPC_OP: begin
                ctrl[CTL_REG_WRITE]   = 1'b1;
                alu_op                = arith_op(funct3, funct7_b30, 1'b1);
            end
            default: alu_op = ALU_ADD;  // Illegal, ctrl stays zero
        endcase

        // ALU op only placed for legal opcodes, keeps bubble all-zero
        if (ctrl != '0) begin
            ctrl[CTL_ALU_OP_MSB:CTL_ALU_OP_LSB] = alu_op;
        end
        // funct3 only for formats that have one, bits belong to imm in U/J
        if (opcode == OPC_JALR || opcode == OPC_BRANCH || opcode == OPC_LOAD ||
            opcode == OPC_STORE || opcode == OPC_OPIMM || opcode == OPC_OP) begin
            ctrl[CTL_FUNCT3_LSB +: FUNCT3_W] = funct3;
        end
    end

    // Immediate by format
    always_comb begin
        case (opcode)
            OPC_JALR, OPC_LOAD, OPC_OPIMM:            // I-type
                imm = {{20{i_instr[31]}}, i_instr[31:20]};
            OPC_STORE:                                // S-type
                imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            OPC_BRANCH:                               // B-type, bit 0 zero
                imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                       i_instr[30:25], i_instr[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:                       // U-type
                imm = {i_instr[31:12], 12'b0};
            OPC_JAL:                                  // J-type
                imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                       i_instr[20], i_instr[30:21], 1'b0};
            default: imm = '0;                        // R-type and illegal
        endcase
    end

    assign o_ctrl = ctrl;
    assign o_imm  = imm;

endmodule

// ==== rv_reg_file.sv ====
//--------------------------------------------------------------------------
// RV32I integer register file. Two combinational read ports, one
// synchronous write port from writeback. x0 reads zero and a write in
// the same cycle is forwarded to the read ports.
//--------------------------------------------------------------------------

module rv_reg_file (
    input                     clk,
    input                     i_rst,       // Sync, active high
    input  rv_pkg::reg_addr_t i_rs1_addr,  // Read port 1 index
    input  rv_pkg::reg_addr_t i_rs2_addr,  // Read port 2 index
    input                     i_we,        // Writeback strobe
    input  rv_pkg::reg_addr_t i_wd_addr,   // Writeback destination
    input  rv_pkg::word_t     i_wd_data,   // Writeback value
    output rv_pkg::word_t     o_rs1_data,
    output rv_pkg::word_t     o_rs2_data
);

    import rv_pkg::*;

    word_t regs [1:NUM_REGS-1];  // x1..x31, no storage for x0
    logic  wr_valid;             // Real write, x0 excluded

    assign wr_valid = i_we && (i_wd_addr != '0);

    // Synchronous write, whole array cleared on reset
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid) begin
            regs[i_wd_addr] <= i_wd_data;
        end
    end

    // One read port, x0 first, then bypass, then array
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_valid && (addr == i_wd_addr)) begin
            data = i_wd_data;  // Write first, read second
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1_addr);
        o_rs2_data = read_port(i_rs2_addr);
    end

endmodule

// ==== id_ex_reg.sv ====
//--------------------------------------------------------------------------
// ID/EX pipeline register. Loads the decoded fields when i_en is high,
// holds them when low (stall). Reset gives a zero control word (bubble).
//--------------------------------------------------------------------------

module id_ex_reg (
    input                  clk,
    input                  i_rst,       // Sync, active high
    input                  i_en,        // Advance, low = stall
    input  rv_pkg::word_t  i_ctrl,      // From decoder
    input  rv_pkg::word_t  i_rs1_data,  // From register file
    input  rv_pkg::word_t  i_rs2_data,
    input  rv_pkg::word_t  i_imm,
    input  rv_pkg::word_t  i_pc,        // PC of the decoded instruction
    input  rv_pkg::instr_t i_instr,
    output rv_pkg::word_t  o_ctrl,
    output rv_pkg::word_t  o_pc,
    output rv_pkg::word_t  o_pc_next,   // Latched PC + 4
    output rv_pkg::word_t  o_rs1_data,
    output rv_pkg::word_t  o_rs2_data,
    output rv_pkg::word_t  o_imm,
    output rv_pkg::instr_t o_instr
);

    import rv_pkg::*;

    word_t pc_next;  // Link address for JAL/JALR

    assign pc_next = i_pc + PC_INC;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_ctrl     <= '0;
            o_pc       <= '0;
            o_pc_next  <= '0;
            o_rs1_data <= '0;
            o_rs2_data <= '0;
            o_imm      <= '0;
            o_instr    <= '0;
        end else if (i_en) begin
            o_ctrl     <= i_ctrl;
            o_pc       <= i_pc;
            o_pc_next  <= pc_next;
            o_rs1_data <= i_rs1_data;
            o_rs2_data <= i_rs2_data;
            o_imm      <= i_imm;
            o_instr    <= i_instr;
        end
        // i_en low keeps every field
    end

endmodule

// ==== rv_decode_stage.sv ====
//--------------------------------------------------------------------------
// RV32I instruction decode stage. Decoder and register file work in
// parallel on the IF/ID word, results land in the ID/EX register one
// cycle later. Writeback enters through the i_wb_* ports.
//--------------------------------------------------------------------------

module rv_decode_stage (
    input                  clk,
    input                  i_rst,       // Sync, active high
    input  rv_pkg::instr_t i_instr,     // From IF/ID
    input  rv_pkg::word_t  i_pc,        // PC of i_instr
    input                  i_en,        // Stage advance level
    input                  i_wb_we,     // Writeback strobe, one cycle
    input  rv_pkg::reg_addr_t i_wb_addr,
    input  rv_pkg::word_t  i_wb_data,
    output rv_pkg::word_t  o_ctrl,      // ID/EX outputs
    output rv_pkg::word_t  o_pc,
    output rv_pkg::word_t  o_pc_next,
    output rv_pkg::word_t  o_rs1_data,
    output rv_pkg::word_t  o_rs2_data,
    output rv_pkg::word_t  o_imm,
    output rv_pkg::instr_t o_instr
);

    import rv_pkg::*;

    word_t     dec_ctrl;                   // Decoder to ID/EX
    word_t     dec_imm;
    reg_addr_t rs1_addr;                   // Source register indices
    reg_addr_t rs2_addr;
    word_t     rs1_data;                   // Register file to ID/EX
    word_t     rs2_data;

    assign rs1_addr = i_instr[19:15];
    assign rs2_addr = i_instr[24:20];

    rv_ctrl_decoder u_decoder (
        .i_instr (i_instr),
        .o_ctrl  (dec_ctrl),
        .o_imm   (dec_imm)
    );

    rv_reg_file u_reg_file (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_we       (i_wb_we),
        .i_wd_addr  (i_wb_addr),
        .i_wd_data  (i_wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    id_ex_reg u_id_ex (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_en       (i_en),
        .i_ctrl     (dec_ctrl),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .i_imm      (dec_imm),
        .i_pc       (i_pc),
        .i_instr    (i_instr),
        .o_ctrl     (o_ctrl),
        .o_pc       (o_pc),
        .o_pc_next  (o_pc_next),
        .o_rs1_data (o_rs1_data),
        .o_rs2_data (o_rs2_data),
        .o_imm      (o_imm),
        .o_instr    (o_instr)
    );

endmodule

// ==== tb_clock_gen.sv ====
//--------------------------------------------------------------------------
// Testbench clock and reset source for the decode stage.
// 100 ns clock period, synchronous reset held high for two rising edges.
//--------------------------------------------------------------------------

module tb_clock_gen (
    output logic o_clk,  // Free-running clock
    output logic o_rst   // Active high, released after 2 cycles
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #50 o_clk = ~o_clk;  // Half period
    end

    initial begin
        o_rst = 1'b1;
        repeat (2) @(posedge o_clk);
        o_rst <= 1'b0;  // Drops with the second edge
    end

endmodule

// ==== tb_decode_stage.sv ====
//--------------------------------------------------------------------------
// Testbench for the RV32I decode stage. Reads vectors from
// decode_patterns.hex, drives one per clock and checks all ID/EX outputs
// one cycle later. Prints one line per test group and a summary.
//--------------------------------------------------------------------------

module tb_decode_stage;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_VECS       = 29;             // Lines in the pattern file
    localparam int VEC_W          = 344;            // 86 hex digits
    localparam int TIMEOUT_CYCLES = NUM_VECS + 20;  // Vectors plus margin
    localparam int SEED           = 91792;

    logic                clk;
    logic                rst;
    logic [31:0]         i_instr;
    logic [31:0]         i_pc;
    logic                i_en;
    logic                i_wb_we;
    logic [4:0]          i_wb_addr;
    logic [31:0]         i_wb_data;
    logic [31:0]         o_ctrl;
    logic [31:0]         o_pc;
    logic [31:0]         o_pc_next;
    logic [31:0]         o_rs1_data;
    logic [31:0]         o_rs2_data;
    logic [31:0]         o_imm;
    logic [31:0]         o_instr;

    logic [VEC_W-1:0]    vecs [0:NUM_VECS-1];  // Stimulus and expected values
    int                  cycle_cnt;
    int                  total_checks;
    int                  total_errors;
    int                  group_checks;
    int                  group_errors;
    int                  groups_done;
    int                  groups_failed;

    tb_clock_gen u_clk_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    rv_decode_stage DUT (
        .clk        (clk),
        .i_rst      (rst),
        .i_instr    (i_instr),
        .i_pc       (i_pc),
        .i_en       (i_en),
        .i_wb_we    (i_wb_we),
        .i_wb_addr  (i_wb_addr),
        .i_wb_data  (i_wb_data),
        .o_ctrl     (o_ctrl),
        .o_pc       (o_pc),
        .o_pc_next  (o_pc_next),
        .o_rs1_data (o_rs1_data),
        .o_rs2_data (o_rs2_data),
        .o_imm      (o_imm),
        .o_instr    (o_instr)
    );

    function automatic string group_name(input int grp);
        string name;
        case (grp)
            1:       name = "reset";
            2:       name = "writeback and read";
            3:       name = "same-cycle bypass";
            4:       name = "decode coverage";
            5:       name = "pipeline fields";
            6:       name = "stall";
            default: name = "unknown";
        endcase
        return name;
    endfunction

    // Apply one vector with a random instruction while stalled
    task automatic drive_vector(input int idx);
        logic [VEC_W-1:0] v;
        v = vecs[idx];
        i_en      <= v[336];
        i_wb_we   <= v[332];
        i_wb_addr <= v[328:324];
        i_wb_data <= v[323:292];
        i_pc      <= v[259:228];
        if (v[336]) begin
            i_instr <= v[291:260];
        end else begin
            i_instr <= $urandom;  // Must not reach the outputs
        end
    endtask

    task automatic compare_field(input int idx, input string name,
                                 input logic [31:0] exp, input logic [31:0] act);
        group_checks++;
        assert (act === exp) else begin
            $display("ERROR vector %0d %s expected %08h actual %08h", idx, name, exp, act);
            group_errors++;
        end
    endtask

    task automatic check_vector(input int idx);
        logic [VEC_W-1:0] v;
        v = vecs[idx];
        compare_field(idx, "o_ctrl",     v[223:192], o_ctrl);
        compare_field(idx, "o_pc",       v[191:160], o_pc);
        compare_field(idx, "o_pc_next",  v[159:128], o_pc_next);
        compare_field(idx, "o_rs1_data", v[127:96],  o_rs1_data);
        compare_field(idx, "o_rs2_data", v[95:64],   o_rs2_data);
        compare_field(idx, "o_imm",      v[63:32],   o_imm);
        compare_field(idx, "o_instr",    v[31:0],    o_instr);
    endtask

    // Print the group result and add its counts to the totals
    task automatic report_group(input int grp);
        $display("Test %0d %s: %0d checks, %0d errors", grp, group_name(grp),
                 group_checks, group_errors);
        groups_done++;
        if (group_errors != 0) begin
            groups_failed++;
        end
        total_checks += group_checks;
        total_errors += group_errors;
        group_checks = 0;
        group_errors = 0;
    endtask

    // Hang guard
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int seed_val;
        int grp;
        seed_val = $urandom(SEED);
        cycle_cnt     = 0;
        total_checks  = 0;
        total_errors  = 0;
        group_checks  = 0;
        group_errors  = 0;
        groups_done   = 0;
        groups_failed = 0;
        i_instr   <= '0;
        i_pc      <= '0;
        i_en      <= 1'b0;
        i_wb_we   <= 1'b0;
        i_wb_addr <= '0;
        i_wb_data <= '0;
        $readmemh("decode_patterns.hex", vecs);

        @(negedge rst);
        @(posedge clk);
        drive_vector(0);
        for (int i = 0; i < NUM_VECS; i++) begin
            @(posedge clk);                // Vector i latched here
            if (i + 1 < NUM_VECS) begin
                drive_vector(i + 1);
            end else begin
                i_en    <= 1'b0;
                i_wb_we <= 1'b0;
            end
            @(negedge clk);                // Outputs settled
            if (vecs[i][224]) begin
                check_vector(i);
            end
            grp = int'(vecs[i][343:340]);
            if (i == NUM_VECS - 1 || int'(vecs[i + 1][343:340]) != grp) begin
                report_group(grp);
            end
        end

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 groups_done, groups_failed, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== decode_patterns.hex ====
// grp en we wbaddr wbdata instr pc | chk | exp ctrl pc pc_next rs1 rs2 imm instr
// One vector per line, fields in that order, digit widths 1 1 1 2 8 8 8 1 8x7
1_0_0_00_00000000_00000000_00000000_1_00000000_00000000_00000000_00000000_00000000_00000000_00000000
1_1_0_00_00000000_002081B3_00001000_1_00000001_00001000_00001004_00000000_00000000_00000000_002081B3
1_1_0_00_00000000_01DF0FB3_00001004_1_00000001_00001004_00001008_00000000_00000000_00000000_01DF0FB3
1_1_0_00_00000000_011802B3_00001008_1_00000001_00001008_0000100C_00000000_00000000_00000000_011802B3
2_0_1_01_11111111_00000000_00000000_0_00000000_00000000_00000000_00000000_00000000_00000000_00000000
2_0_1_02_22222222_00000000_00000000_0_00000000_00000000_00000000_00000000_00000000_00000000_00000000
2_0_1_07_80000007_00000000_00000000_0_00000000_00000000_00000000_00000000_00000000_00000000_00000000
2_0_1_00_DEADBEEF_00000000_00000000_0_00000000_00000000_00000000_00000000_00000000_00000000_00000000
2_1_0_00_00000000_40208233_0000100C_1_00000801_0000100C_00001010_11111111_22222222_00000000_40208233
2_1_0_00_00000000_0003E333_00001010_1_00006601_00001010_00001014_80000007_00000000_00000000_0003E333
3_1_1_09_CAFEF00D_00148533_00001014_1_00000001_00001014_00001018_CAFEF00D_11111111_00000000_00148533
3_1_1_00_12345678_000005B3_00001018_1_00000001_00001018_0000101C_00000000_00000000_00000000_000005B3
4_1_0_00_00000000_FFF08293_0000101C_1_00000011_0000101C_00001020_11111111_00000000_FFFFFFFF_FFF08293
4_1_0_00_00000000_00812303_00001020_1_0000201B_00001020_00001024_22222222_00000000_00000008_00812303
4_1_0_00_00000000_FE70AE23_00001024_1_00002014_00001024_00001028_11111111_80000007_FFFFFFFC_FE70AE23
4_1_0_00_00000000_FE2088E3_00001028_1_00000840_00001028_0000102C_11111111_22222222_FFFFFFF0_FE2088E3
4_1_0_00_00000000_00039463_0000102C_1_00001840_0000102C_00001030_80000007_00000000_00000008_00039463
4_1_0_00_00000000_FF9FF0EF_00001030_1_000000B1_00001030_00001034_00000000_00000000_FFFFFFF8_FF9FF0EF
4_1_0_00_00000000_00408067_00001034_1_00000091_00001034_00001038_11111111_00000000_00000004_00408067
4_1_0_00_00000000_ABCDE637_00001038_1_00000F11_00001038_0000103C_00000000_00000000_ABCDE000_ABCDE637
4_1_0_00_00000000_80000697_0000103C_1_00000031_0000103C_00001040_00000000_00000000_80000000_80000697
4_1_0_00_00000000_4043D713_00001040_1_00005D11_00001040_00001044_80000007_00000000_00000404_4043D713
4_1_0_00_00000000_FFFFFFFF_00001044_1_00000000_00001044_00001048_00000000_00000000_00000000_FFFFFFFF
5_1_0_00_00000000_002081B3_FFFFFFFC_1_00000001_FFFFFFFC_00000000_11111111_22222222_00000000_002081B3
5_1_0_00_00000000_00000013_00000100_1_00000011_00000100_00000104_00000000_00000000_00000000_00000013
6_0_0_00_00000000_00000000_0BADF00D_1_00000011_00000100_00000104_00000000_00000000_00000000_00000013
6_0_1_01_5A5A5A5A_00000000_12345678_1_00000011_00000100_00000104_00000000_00000000_00000000_00000013
6_0_0_00_00000000_00000000_DEADBEE0_1_00000011_00000100_00000104_00000000_00000000_00000000_00000013
6_1_0_00_00000000_002081B3_00000104_1_00000001_00000104_00000108_5A5A5A5A_22222222_00000000_002081B3

// ==== all.f ====
rv_pkg.sv
rv_ctrl_decoder.sv
rv_reg_file.sv
id_ex_reg.sv
rv_decode_stage.sv
tb_clock_gen.sv
tb_decode_stage.sv

// ==== Makefile ====
TOP = tb_decode_stage
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "\*\*\* FAILED \*\*\*" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
